// File: include/cache_params.svh
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// --------------------
// cache geometry.
// --------------------
`define CACHE_SETS 8        // sets per way.
`define CACHE_WAYS 2        // way select is a single bit.

// --------------------
// address fields.
// --------------------
`define TAG_BITS 9          // address bits 15 to 7.
`define INDEX_BITS 3        // address bits 6 to 4.
`define OFFSET_BITS 3       // word within the line.

// line as seen on the memory port.
`define LINE_BITS 128

`endif

// File: hdl/lc3b_mem_pkg.sv
`include "cache_params.svh"

// memory side types shared by cpu port, datapath and merge logic.
package lc3b_mem_pkg;

	// --------------------
	// cpu words.
	// --------------------
	typedef logic [15:0] lc3b_word;       // data or byte address.
	typedef logic [1:0] lc3b_mem_wmask;   // bit 0 is the low byte.

	// byte address as the cache splits it.
	typedef struct packed {
		logic [`TAG_BITS-1:0] tag;          // compared against tag array.
		logic [`INDEX_BITS-1:0] index;      // set select.
		logic [`OFFSET_BITS-1:0] offset;    // word in line.
		logic byte_sel;                     // unused, accesses are aligned.
	} cache_addr_t;

	// --------------------
	// cache line.
	// --------------------
	// the same 128 bits are read as words and written as bytes.
	typedef union packed {
		lc3b_word [(`LINE_BITS/16)-1:0] words;   // read side view.
		logic [(`LINE_BITS/8)-1:0][7:0] bytes;   // byte masked store view.
	} cache_line_t;

endpackage

// File: hdl/cache_ctrl_pkg.sv
// controller side types.
package cache_ctrl_pkg;

	// --------------------
	// controller states.
	// --------------------
	typedef enum logic [1:0] {
		idle       = 2'b00,   // waiting for a cpu strobe.
		compare    = 2'b01,   // tag lookup, respond on hit.
		write_back = 2'b10,   // dirty victim goes out.
		allocate   = 2'b11    // new line comes in.
	} cache_state_t;

endpackage

// File: hdl/cache_ctrl_if.sv
`timescale 1ns/1ns

// strobes between the controller and the datapath.
interface cache_ctrl_if;

	// driven by the controller.
	logic way_from_lru;       // victim way instead of hit way.
	logic addr_from_victim;   // victim tag on pmem_address.
	logic load_line;          // write memory line, valid set, dirty clear.
	logic store_word;         // merge cpu word, dirty set.
	logic touch_lru;          // used way becomes most recent.

	// driven by the datapath.
	logic hit;                // tag match in a valid way.
	logic victim_dirty;       // lru way must be written back.

	modport control (
		output way_from_lru, addr_from_victim, load_line, store_word, touch_lru,
		input hit, victim_dirty
	);

	modport datapath (
		input way_from_lru, addr_from_victim, load_line, store_word, touch_lru,
		output hit, victim_dirty
	);

endinterface

// File: hdl/line_word_merge.sv
`timescale 1ns/1ns
`include "cache_params.svh"

// word read and byte masked word write on one cache line.
module line_word_merge (
	input lc3b_mem_pkg::cache_line_t line,
	input logic [`OFFSET_BITS-1:0] offset,
	input lc3b_mem_pkg::lc3b_word wdata,
	input lc3b_mem_pkg::lc3b_mem_wmask byte_enable,
	output lc3b_mem_pkg::lc3b_word rdata,
	output lc3b_mem_pkg::cache_line_t merged
);
	import lc3b_mem_pkg::*;

	lc3b_word cur_word;              // addressed word before the store.
	logic [`OFFSET_BITS:0] lo_byte;  // byte index of the low half.
	logic [`OFFSET_BITS:0] hi_byte;  // byte index of the high half.

	// --------------------
	// read side.
	// --------------------
	assign cur_word = line.words[offset];   // word view.
	assign rdata = cur_word;

	// --------------------
	// write side.
	// --------------------
	assign lo_byte = {offset, 1'b0};
	assign hi_byte = {offset, 1'b1};

	// untouched bytes keep the line contents.
	always_comb begin
		merged = line;
		if (byte_enable[0]) begin
			merged.bytes[lo_byte] = wdata[7:0];    // low byte.
		end
		if (byte_enable[1]) begin
			merged.bytes[hi_byte] = wdata[15:8];   // high byte.
		end
	end

endmodule

// File: hdl/cache_datapath.sv
`timescale 1ns/1ns
`include "cache_params.svh"

// arrays, tag compare, victim select and memory side muxing.
module cache_datapath (
	input logic clk,
	input logic reset,
	cache_ctrl_if.datapath ctrl,
	input lc3b_mem_pkg::lc3b_word mem_address,
	input lc3b_mem_pkg::lc3b_word mem_wdata,
	input lc3b_mem_pkg::lc3b_mem_wmask mem_byte_enable,
	output lc3b_mem_pkg::lc3b_word mem_rdata,
	input lc3b_mem_pkg::cache_line_t pmem_rdata,
	output lc3b_mem_pkg::lc3b_word pmem_address,
	output lc3b_mem_pkg::cache_line_t pmem_wdata
);
	import lc3b_mem_pkg::*;

	// --------------------
	// arrays.
	// --------------------
	cache_line_t data_arr [`CACHE_SETS][`CACHE_WAYS];         // line payload.
	logic [`TAG_BITS-1:0] tag_arr [`CACHE_SETS][`CACHE_WAYS]; // line tags.
	logic valid_arr [`CACHE_SETS][`CACHE_WAYS];
	logic dirty_arr [`CACHE_SETS][`CACHE_WAYS];
	logic lru_arr [`CACHE_SETS];   // holds the least recent way.

	cache_addr_t req;                     // request address fields.
	logic [`CACHE_WAYS-1:0] way_hit;      // per way match.
	logic hit_way;                        // which way matched.
	logic victim_way;                     // lru way of the set.
	logic sel_way;                        // way the strobes act on.
	logic [`TAG_BITS-1:0] line_tag;       // tag for pmem_address.

	lc3b_word way_rdata [`CACHE_WAYS];    // addressed word per way.
	cache_line_t way_merged [`CACHE_WAYS]; // store merged line per way.

	assign req = mem_address;

	// --------------------
	// hit logic.
	// --------------------
	always_comb begin
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			way_hit[w] = valid_arr[req.index][w] && (tag_arr[req.index][w] == req.tag);
		end
	end

	assign ctrl.hit = |way_hit;
	assign hit_way = way_hit[1];   // two ways only, way 0 otherwise.

	// victim and way select.
	assign victim_way = lru_arr[req.index];
	assign sel_way = ctrl.way_from_lru ? victim_way : hit_way;
	assign ctrl.victim_dirty = dirty_arr[req.index][victim_way];

	// --------------------
	// word extract and merge.
	// --------------------
	for (genvar w = 0; w < `CACHE_WAYS; w++) begin : g_merge
		line_word_merge i_line_word_merge (
			.line(data_arr[req.index][w]),
			.offset(req.offset),
			.wdata(mem_wdata),
			.byte_enable(mem_byte_enable),
			.rdata(way_rdata[w]),
			.merged(way_merged[w])
		);
	end

	assign mem_rdata = way_rdata[sel_way];   // valid with mem_resp.

	// --------------------
	// memory side.
	// --------------------
	assign line_tag = ctrl.addr_from_victim ? tag_arr[req.index][sel_way] : req.tag;
	assign pmem_address = {line_tag, req.index, {(`OFFSET_BITS + 1){1'b0}}};  // line aligned.
	assign pmem_wdata = data_arr[req.index][sel_way];   // victim line in write_back.

	// payload writes, no reset.
	always_ff @(posedge clk) begin
		if (ctrl.load_line) begin
			data_arr[req.index][sel_way] <= pmem_rdata;   // fill from memory.
			tag_arr[req.index][sel_way] <= req.tag;
		end else if (ctrl.store_word) begin
			data_arr[req.index][sel_way] <= way_merged[sel_way];   // cpu store.
		end
	end

	// state bits.
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int s = 0; s < `CACHE_SETS; s++) begin
				lru_arr[s] <= 1'b0;
				for (int w = 0; w < `CACHE_WAYS; w++) begin
					valid_arr[s][w] <= 1'b0;
					dirty_arr[s][w] <= 1'b0;
				end
			end
		end else begin
			if (ctrl.load_line) begin
				valid_arr[req.index][sel_way] <= 1'b1;
				dirty_arr[req.index][sel_way] <= 1'b0;   // clean copy of memory.
			end else if (ctrl.store_word) begin
				dirty_arr[req.index][sel_way] <= 1'b1;
			end
			if (ctrl.touch_lru) begin
				lru_arr[req.index] <= ~sel_way;   // other way is now oldest.
			end
		end
	end

	// --------------------
	// checks.
	// --------------------
	// controller only stores into a way that matched.
	a_store_needs_hit : assert property (
		@(posedge clk) disable iff (reset) ctrl.store_word |-> ctrl.hit
	);

	// fill and store never target the arrays in one cycle.
	a_no_load_and_store : assert property (
		@(posedge clk) disable iff (reset) !(ctrl.load_line && ctrl.store_word)
	);

endmodule

// File: hdl/cache_control.sv
`timescale 1ns/1ns

// compare, write back and allocate sequencing.
module cache_control (
	input logic clk,
	input logic reset,
	cache_ctrl_if.control ctrl,
	input logic mem_read,
	input logic mem_write,
	output logic mem_resp,
	input logic pmem_resp,
	output logic pmem_read,
	output logic pmem_write
);
	import cache_ctrl_pkg::*;

	cache_state_t state;        // current state.
	cache_state_t next_state;

	// --------------------
	// state register.
	// --------------------
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= idle;
		end else begin
			state <= next_state;
		end
	end

	// --------------------
	// next state and outputs.
	// --------------------
	always_comb begin
		next_state = state;
		mem_resp = 1'b0;
		pmem_read = 1'b0;
		pmem_write = 1'b0;
		ctrl.way_from_lru = 1'b0;
		ctrl.addr_from_victim = 1'b0;
		ctrl.load_line = 1'b0;
		ctrl.store_word = 1'b0;
		ctrl.touch_lru = 1'b0;

		unique case (state)
			idle: begin
				if (mem_read || mem_write) begin
					next_state = compare;   // lookup on next cycle.
				end
			end

			compare: begin
				if (ctrl.hit) begin
					mem_resp = 1'b1;               // rdata valid this cycle.
					ctrl.store_word = mem_write;   // write hit lands on this edge.
					ctrl.touch_lru = 1'b1;
					next_state = idle;             // cpu drops the request next.
				end else if (ctrl.victim_dirty) begin
					next_state = write_back;
				end else begin
					next_state = allocate;         // clean victim is overwritten.
				end
			end

			write_back: begin
				pmem_write = 1'b1;             // held until pmem_resp.
				ctrl.way_from_lru = 1'b1;
				ctrl.addr_from_victim = 1'b1;   // victim line address.
				if (pmem_resp) begin
					next_state = allocate;
				end
			end

			allocate: begin
				pmem_read = 1'b1;
				ctrl.way_from_lru = 1'b1;   // fill the victim way.
				if (pmem_resp) begin
					ctrl.load_line = 1'b1;   // line captured on this edge.
					next_state = compare;    // retry hits now.
				end
			end

			default: begin
				next_state = idle;
			end
		endcase
	end

	// --------------------
	// checks.
	// --------------------
	a_one_pmem_strobe : assert property (
		@(posedge clk) disable iff (reset) !(pmem_read && pmem_write)
	);

	// cpu sees one response per request.
	a_resp_pulse : assert property (
		@(posedge clk) disable iff (reset) mem_resp |=> !mem_resp
	);

endmodule

// File: hdl/lc3b_cache.sv
`timescale 1ns/1ns
`include "cache_params.svh"

// 2 way write back cache between the cpu and physical memory.
module lc3b_cache (
	input logic clk,
	input logic reset,

	// cpu port.
	input logic mem_read,
	input logic mem_write,
	input lc3b_mem_pkg::lc3b_mem_wmask mem_byte_enable,
	input lc3b_mem_pkg::lc3b_word mem_address,
	input lc3b_mem_pkg::lc3b_word mem_wdata,
	output logic mem_resp,
	output lc3b_mem_pkg::lc3b_word mem_rdata,

	// physical memory port.
	input logic pmem_resp,
	input logic [`LINE_BITS-1:0] pmem_rdata,
	output logic pmem_read,
	output logic pmem_write,
	output lc3b_mem_pkg::lc3b_word pmem_address,
	output logic [`LINE_BITS-1:0] pmem_wdata
);

	cache_ctrl_if ctrl_if ();   // controller to datapath strobes.

	// --------------------
	// sequencing.
	// --------------------
	cache_control i_cache_control (
		.clk(clk),
		.reset(reset),
		.ctrl(ctrl_if.control),
		.mem_read(mem_read),
		.mem_write(mem_write),
		.mem_resp(mem_resp),
		.pmem_resp(pmem_resp),
		.pmem_read(pmem_read),
		.pmem_write(pmem_write)
	);

	// arrays and muxing.
	cache_datapath i_cache_datapath (
		.clk(clk),
		.reset(reset),
		.ctrl(ctrl_if.datapath),
		.mem_address(mem_address),
		.mem_wdata(mem_wdata),
		.mem_byte_enable(mem_byte_enable),
		.mem_rdata(mem_rdata),
		.pmem_rdata(pmem_rdata),
		.pmem_address(pmem_address),
		.pmem_wdata(pmem_wdata)
	);

endmodule

// File: verification/tb_pmem_model.sv
`timescale 1ns/1ns
`include "cache_params.svh"

// physical memory behind the cache, one line per 16 bytes.
module tb_pmem_model (
	input logic clk,
	input logic pmem_read,
	input logic pmem_write,
	input logic [15:0] pmem_address,
	input logic [`LINE_BITS-1:0] pmem_wdata,
	output logic pmem_resp,
	output logic [`LINE_BITS-1:0] pmem_rdata,
	output int read_count,                 // lines served to the cache.
	output int write_count,                // lines written back.
	output logic [15:0] last_wb_addr,
	output logic [`LINE_BITS-1:0] last_wb_line
);

	logic [`LINE_BITS-1:0] lines [4096];   // full 64k byte space.
	integer seed;                          // latency draw.
	int latency;

	initial begin
		seed = 97801;
		pmem_resp = 1'b0;
		pmem_rdata = '0;
		read_count = 0;
		write_count = 0;
		last_wb_addr = '0;
		last_wb_line = '0;

		// each word starts as its own byte address xor a5a5.
		for (int l = 0; l < 4096; l++) begin
			for (int w = 0; w < 8; w++) begin
				lines[l][w*16 +: 16] = 16'(l*16 + w*2) ^ 16'hA5A5;
			end
		end

		// --------------------
		// request service.
		// --------------------
		forever begin
			@(posedge clk);
			#10;
			pmem_resp = 1'b0;   // pulse lasts one cycle.
			if (pmem_read || pmem_write) begin
				latency = 1 + ($unsigned($random(seed)) % 4);   // 1 to 4 cycles.
				repeat (latency - 1) begin
					@(posedge clk);
					#10;
				end
				if (pmem_write) begin
					lines[pmem_address[15:4]] = pmem_wdata;
					last_wb_addr = pmem_address;
					last_wb_line = pmem_wdata;
					write_count++;
				end else begin
					pmem_rdata = lines[pmem_address[15:4]];   // valid with resp.
					read_count++;
				end
				pmem_resp = 1'b1;
			end
		end
	end

endmodule

// File: verification/tb_lc3b_cache.sv
`timescale 1ns/1ns
`include "cache_params.svh"

// drives the cache through a table of accesses against a reference model.
module tb_lc3b_cache;

	localparam int ROWS = 25;
	localparam int TIMEOUT = 200;   // cycles per wait.

	// stimulus row with hand derived memory traffic.
	typedef struct packed {
		logic wr;             // store when set.
		logic [15:0] addr;
		logic [15:0] wdata;
		logic [1:0] mask;
		logic fetch;          // one line read expected.
		logic wb;             // one write back expected.
	} row_t;

	logic clk;
	logic reset;
	logic mem_read;
	logic mem_write;
	logic [1:0] mem_byte_enable;
	logic [15:0] mem_address;
	logic [15:0] mem_wdata;
	logic mem_resp;
	logic [15:0] mem_rdata;
	logic pmem_resp;
	logic [`LINE_BITS-1:0] pmem_rdata;
	logic pmem_read;
	logic pmem_write;
	logic [15:0] pmem_address;
	logic [`LINE_BITS-1:0] pmem_wdata;
	int read_count;
	int write_count;
	logic [15:0] last_wb_addr;
	logic [`LINE_BITS-1:0] last_wb_line;

	int check_count = 0;
	int error_count = 0;

	// --------------------
	// reference model.
	// --------------------
	logic [15:0] image [32768];                          // cpu view of memory.
	logic [`TAG_BITS-1:0] ref_tag [`CACHE_SETS][`CACHE_WAYS];
	logic ref_valid [`CACHE_SETS][`CACHE_WAYS];
	logic ref_dirty [`CACHE_SETS][`CACHE_WAYS];
	logic ref_lru [`CACHE_SETS];                         // least recent way.

	// wr, address, wdata, mask, fetch, write back.
	row_t table_rows [ROWS] = '{
		'{1'b0, 16'h0012, 16'h0000, 2'b00, 1'b1, 1'b0},   // cold miss.
		'{1'b0, 16'h0012, 16'h0000, 2'b00, 1'b0, 1'b0},   // same word hits.
		'{1'b0, 16'h001E, 16'h0000, 2'b00, 1'b0, 1'b0},
		'{1'b1, 16'h0014, 16'h1234, 2'b01, 1'b0, 1'b0},   // low byte only.
		'{1'b1, 16'h0016, 16'h5678, 2'b10, 1'b0, 1'b0},   // high byte only.
		'{1'b1, 16'h0018, 16'h9ABC, 2'b11, 1'b0, 1'b0},
		'{1'b0, 16'h0014, 16'h0000, 2'b00, 1'b0, 1'b0},
		'{1'b0, 16'h0016, 16'h0000, 2'b00, 1'b0, 1'b0},
		'{1'b0, 16'h0018, 16'h0000, 2'b00, 1'b0, 1'b0},
		'{1'b0, 16'h0020, 16'h0000, 2'b00, 1'b1, 1'b0},   // set 2 tags 0, 1, 2.
		'{1'b0, 16'h00A0, 16'h0000, 2'b00, 1'b1, 1'b0},
		'{1'b0, 16'h0020, 16'h0000, 2'b00, 1'b0, 1'b0},
		'{1'b0, 16'h0120, 16'h0000, 2'b00, 1'b1, 1'b0},   // tag 1 is the victim.
		'{1'b0, 16'h0020, 16'h0000, 2'b00, 1'b0, 1'b0},
		'{1'b0, 16'h00A0, 16'h0000, 2'b00, 1'b1, 1'b0},   // evicted, fetch again.
		'{1'b0, 16'h0092, 16'h0000, 2'b00, 1'b1, 1'b0},
		'{1'b1, 16'h0094, 16'hCAFE, 2'b11, 1'b0, 1'b0},
		'{1'b0, 16'h0110, 16'h0000, 2'b00, 1'b1, 1'b1},   // dirty tag 0 goes out.
		'{1'b0, 16'h0014, 16'h0000, 2'b00, 1'b1, 1'b1},   // dirty tag 1 goes out.
		'{1'b0, 16'h0094, 16'h0000, 2'b00, 1'b1, 1'b0},
		'{1'b0, 16'h0018, 16'h0000, 2'b00, 1'b0, 1'b0},
		'{1'b1, 16'h7FF6, 16'hBEEF, 2'b11, 1'b1, 1'b0},   // write allocate.
		'{1'b0, 16'h7FF6, 16'h0000, 2'b00, 1'b0, 1'b0},
		'{1'b0, 16'h7FF4, 16'h0000, 2'b00, 1'b0, 1'b0},
		'{1'b0, 16'hFFFE, 16'h0000, 2'b00, 1'b1, 1'b0}
	};

	lc3b_cache i_lc3b_cache (.*);

	tb_pmem_model i_pmem (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;   // 100 ns period.
	end

	task automatic check_value(input string name, input logic [127:0] got,
			input logic [127:0] exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
		end
	endtask

	// line of the reference image that starts at base.
	function automatic logic [`LINE_BITS-1:0] image_line(input logic [15:0] base);
		logic [`LINE_BITS-1:0] line;
		for (int w = 0; w < 8; w++) begin
			line[w*16 +: 16] = image[{base[15:4], 3'(w)}];
		end
		return line;
	endfunction

	// updates tags, lru and image, returns read data and victim line.
	task automatic predict_access(input row_t r, output logic [15:0] rdata,
			output logic [15:0] wb_addr, output logic [`LINE_BITS-1:0] wb_line);
		logic [`INDEX_BITS-1:0] idx;
		logic [`TAG_BITS-1:0] tag;
		logic victim;
		int used;
		idx = r.addr[6:4];
		tag = r.addr[15:7];
		used = -1;
		wb_addr = '0;
		wb_line = '0;
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			if (ref_valid[idx][w] && ref_tag[idx][w] == tag) used = w;
		end
		if (used < 0) begin
			victim = ref_lru[idx];   // miss replaces the least recent way.
			if (ref_valid[idx][victim] && ref_dirty[idx][victim]) begin
				wb_addr = {ref_tag[idx][victim], idx, 4'h0};
				wb_line = image_line(wb_addr);
			end
			ref_valid[idx][victim] = 1'b1;
			ref_dirty[idx][victim] = 1'b0;
			ref_tag[idx][victim] = tag;
			used = int'(victim);
		end
		if (r.wr) begin
			if (r.mask[0]) image[r.addr[15:1]][7:0] = r.wdata[7:0];
			if (r.mask[1]) image[r.addr[15:1]][15:8] = r.wdata[15:8];
			ref_dirty[idx][used] = 1'b1;
		end
		ref_lru[idx] = (used == 0);   // the other way is now oldest.
		rdata = image[r.addr[15:1]];
	endtask

	// samples mid cycle until mem_resp or timeout.
	task automatic wait_for_resp(output bit timed_out, output logic [15:0] rdata,
			output int cycles);
		timed_out = 1'b1;
		rdata = '0;
		cycles = 0;
		while (timed_out && cycles < TIMEOUT) begin
			@(negedge clk);
			cycles++;
			if (mem_resp) begin
				timed_out = 1'b0;
				rdata = mem_rdata;
			end
		end
	endtask

	// --------------------
	// main sequence.
	// --------------------
	initial begin
		bit timed_out;
		bit stop;
		int cycles;
		int rows_run;
		int reads_before;
		int writes_before;
		int errors_before;
		logic [15:0] got_rdata;
		logic [15:0] exp_rdata;
		logic [15:0] exp_wb_addr;
		logic [`LINE_BITS-1:0] exp_wb_line;

		reset = 1'b1;
		mem_read = 1'b0;
		mem_write = 1'b0;
		mem_byte_enable = 2'b00;
		mem_address = '0;
		mem_wdata = '0;
		stop = 1'b0;
		rows_run = 0;
		for (int a = 0; a < 32768; a++) begin
			image[a] = {a[14:0], 1'b0} ^ 16'hA5A5;   // same pattern as memory.
		end
		for (int s = 0; s < `CACHE_SETS; s++) begin
			ref_lru[s] = 1'b0;
			for (int w = 0; w < `CACHE_WAYS; w++) begin
				ref_valid[s][w] = 1'b0;
				ref_dirty[s][w] = 1'b0;
				ref_tag[s][w] = '0;
			end
		end

		repeat (5) @(posedge clk);
		#10;
		reset = 1'b0;
		@(negedge clk);
		check_value("mem_resp", mem_resp, 0);   // quiet after reset.
		check_value("pmem_read", pmem_read, 0);
		check_value("pmem_write", pmem_write, 0);

		for (int i = 0; i < ROWS && !stop; i++) begin
			@(posedge clk);
			#10;
			mem_read = !table_rows[i].wr;
			mem_write = table_rows[i].wr;
			mem_address = table_rows[i].addr;
			mem_wdata = table_rows[i].wdata;
			mem_byte_enable = table_rows[i].mask;
			reads_before = read_count;
			writes_before = write_count;
			errors_before = error_count;
			predict_access(table_rows[i], exp_rdata, exp_wb_addr, exp_wb_line);
			wait_for_resp(timed_out, got_rdata, cycles);
			if (timed_out) begin
				$display("row %0d: the cache gave no response within %0d cycles", i, TIMEOUT);
				error_count++;
				stop = 1'b1;
			end else begin
				if (!table_rows[i].wr) check_value("mem_rdata", got_rdata, exp_rdata);
				check_value("pmem_read count", read_count - reads_before, table_rows[i].fetch);
				check_value("pmem_write count", write_count - writes_before, table_rows[i].wb);
				if (!table_rows[i].fetch) check_value("hit latency", cycles, 2);
				if (table_rows[i].wb) begin
					check_value("pmem_address", last_wb_addr, exp_wb_addr);
					check_value("pmem_wdata", last_wb_line, exp_wb_line);
				end
				@(posedge clk);
				#10;
				mem_read = 1'b0;   // request ends after the response.
				mem_write = 1'b0;
				rows_run++;
				if (error_count == errors_before) begin
					$display("row %0d addr 0x%h ok", i, table_rows[i].addr);
				end else begin
					$display("row %0d addr 0x%h mismatch", i, table_rows[i].addr);
				end
			end
		end

		$display("rows %0d, checks %0d, errors %0d", rows_run, check_count, error_count);
		if (error_count == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// File: sim.f
+incdir+include
hdl/lc3b_mem_pkg.sv
hdl/cache_ctrl_pkg.sv
hdl/cache_ctrl_if.sv
hdl/line_word_merge.sv
hdl/cache_datapath.sv
hdl/cache_control.sv
hdl/lc3b_cache.sv
verification/tb_pmem_model.sv
verification/tb_lc3b_cache.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the cache testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_lc3b_cache

verilator --binary --timing --assert -Wno-fatal \
	--top-module "$TOP" -f sim.f -Mdir obj_dir -o "$TOP"
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TEST RESULT: PASS" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1
